// ==== hdl/opn_addr_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_addr_port (
    input  logic                       clk,
    input  logic                       rst,
    input  opn_reg_pkg::reg_data_t     din,
    input  logic                       write,
    input  logic [1:0]                 addr,
    output opn_reg_pkg::reg_addr_t     sel_reg,
    output logic                       part,
    output logic                       data_we,
    output opn_timing_pkg::div_setting_t div_setting
);

    logic addr_we;

    assign addr_we = write && !addr[0];
    assign data_we = write && addr[0];     // Only strobe seen downstream

    // Register pointer and part bit
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            part    <= 1'b0;
        end else if (addr_we) begin
            sel_reg <= din;
            part    <= addr[1];
        end
    end

    // Prescaler commands act on selection alone
    // The part bit is ignored here
    always_ff @(posedge clk) begin
        if (rst) begin
            div_setting <= opn_timing_pkg::DIV_RESET;
        end else if (addr_we) begin
            case (din)
                opn_reg_pkg::REG_CLK_N6: div_setting[1] <= 1'b1;
                opn_reg_pkg::REG_CLK_N3: div_setting[0] <= 1'b1;
                opn_reg_pkg::REG_CLK_N2: div_setting    <= 2'b00;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_busy.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_busy (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic data_we,
    output logic busy
);

    opn_timing_pkg::busy_cnt_t cnt;
    logic                      data_we_d;
    logic                      we_rise;

    assign we_rise = data_we && !data_we_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_we_d <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
        end else begin
            data_we_d <= data_we;
            if (we_rise) begin
                busy <= 1'b1;   // Restarts on every new write
                cnt  <= '0;
            end else if (busy && clk_en) begin
                if (cnt == opn_timing_pkg::busy_cnt_t'(opn_timing_pkg::BUSY_PULSES - 1))
                    busy <= 1'b0;
                cnt <= cnt + 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_clk_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_clk_div (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,
    input  opn_timing_pkg::div_setting_t div_setting,
    output logic                         clk_en
);

    opn_timing_pkg::div_cnt_t     cnt;
    opn_timing_pkg::div_cnt_t     ratio;
    opn_timing_pkg::div_cnt_t     last_cnt;
    opn_timing_pkg::div_setting_t cur_setting;  // Setting the count runs on
    logic                         changed;

    // Bit 0 wins over bit 1
    always_comb begin
        if (div_setting[0])
            ratio = opn_timing_pkg::DIV_BY_3;
        else if (div_setting[1])
            ratio = opn_timing_pkg::DIV_BY_6;
        else
            ratio = opn_timing_pkg::DIV_BY_2;
    end

    assign last_cnt = opn_timing_pkg::div_cnt_t'(ratio - 3'd1);
    assign changed  = div_setting != cur_setting;
    assign clk_en   = cen && !changed && (cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            cur_setting <= opn_timing_pkg::DIV_RESET;
        end else if (cen) begin
            cur_setting <= div_setting;
            if (changed)
                cnt <= 3'd1;    // This cen is the first of the new count
            else if (cnt == last_cnt)
                cnt <= '0;
            else
                cnt <= cnt + 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_global_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_global_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_en,
    input  logic                   data_we,
    input  opn_reg_pkg::reg_addr_t sel_reg,
    input  logic                   part,
    input  opn_reg_pkg::reg_data_t din,
    output opn_reg_pkg::lfo_freq_t lfo_freq,
    output logic                   lfo_en,
    output opn_reg_pkg::timer_a_t  value_a,
    output opn_reg_pkg::timer_b_t  value_b,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   enable_irq_a,
    output logic                   enable_irq_b,
    output logic                   clr_flag_a,
    output logic                   clr_flag_b,
    output logic                   fast_timers,
    output logic                   eg_stop,
    output logic                   pg_stop,
    output logic                   csm,
    output logic                   effect
);

    logic global_we;

    assign global_we = data_we && !part;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfo_freq     <= '0;
            lfo_en       <= 1'b0;
            value_a      <= '0;
            value_b      <= '0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            fast_timers  <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            csm          <= 1'b0;
            effect       <= 1'b0;
        end else if (global_we) begin
            case (sel_reg)
                opn_reg_pkg::REG_TESTYM: begin
                    eg_stop     <= din[5];
                    pg_stop     <= din[3];
                    fast_timers <= din[2];
                end
                opn_reg_pkg::REG_LFO:   {lfo_en, lfo_freq} <= din[3:0];
                opn_reg_pkg::REG_CLKA1: value_a[9:2] <= din;
                opn_reg_pkg::REG_CLKA2: value_a[1:0] <= din[1:0];
                opn_reg_pkg::REG_CLKB:  value_b      <= din;
                opn_reg_pkg::REG_TIMER: begin
                    // Mode bits: 01 and 11 effect, 10 CSM plus effect
                    effect <= |din[7:6];
                    csm    <= din[7:6] == 2'b10;
                    {clr_flag_b, clr_flag_a,
                     enable_irq_b, enable_irq_a,
                     load_b, load_a} <= din[5:0];
                end
                default: ;
            endcase
        end else if (clk_en && !data_we) begin
            clr_flag_a <= 1'b0;     // One-shot flag resets
            clr_flag_b <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_mmr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  opn_reg_pkg::reg_data_t din,
    input  logic                   write,
    input  logic [1:0]             addr,
    output logic                   clk_en,
    output logic                   busy,
    output opn_reg_pkg::lfo_freq_t lfo_freq,
    output logic                   lfo_en,
    output opn_reg_pkg::timer_a_t  value_a,
    output opn_reg_pkg::timer_b_t  value_b,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   enable_irq_a,
    output logic                   enable_irq_b,
    output logic                   clr_flag_a,
    output logic                   clr_flag_b,
    output logic                   fast_timers,
    output logic                   eg_stop,
    output logic                   pg_stop,
    output logic                   csm,
    output logic                   effect,
    output opn_reg_pkg::pcm_t      pcm,
    output logic                   pcm_en,
    output logic                   pcm_wr,
    output logic                   up_keyon,
    output opn_reg_pkg::ch_up_t    ch_up,
    output opn_reg_pkg::op_up_t    op_up,
    output opn_reg_pkg::ch_t       up_ch,
    output opn_reg_pkg::op_t       up_op,
    output opn_reg_pkg::reg_data_t slot_din
);

    opn_reg_pkg::reg_addr_t       sel_reg;
    logic                         part;
    logic                         data_we;
    opn_timing_pkg::div_setting_t div_setting;

    opn_addr_port i_addr_port (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .write       (write),
        .addr        (addr),
        .sel_reg     (sel_reg),
        .part        (part),
        .data_we     (data_we),
        .div_setting (div_setting)
    );

    opn_clk_div i_clk_div (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .div_setting (div_setting),
        .clk_en      (clk_en)
    );

    opn_global_regs i_global_regs (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .data_we      (data_we),
        .sel_reg      (sel_reg),
        .part         (part),
        .din          (din),
        .lfo_freq     (lfo_freq),
        .lfo_en       (lfo_en),
        .value_a      (value_a),
        .value_b      (value_b),
        .load_a       (load_a),
        .load_b       (load_b),
        .enable_irq_a (enable_irq_a),
        .enable_irq_b (enable_irq_b),
        .clr_flag_a   (clr_flag_a),
        .clr_flag_b   (clr_flag_b),
        .fast_timers  (fast_timers),
        .eg_stop      (eg_stop),
        .pg_stop      (pg_stop),
        .csm          (csm),
        .effect       (effect)
    );

    opn_pcm_regs i_pcm_regs (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .data_we (data_we),
        .sel_reg (sel_reg),
        .part    (part),
        .din     (din),
        .pcm     (pcm),
        .pcm_en  (pcm_en),
        .pcm_wr  (pcm_wr)
    );

    // Strobes for the external operator register file
    opn_slot_decode i_slot_decode (
        .clk      (clk),
        .rst      (rst),
        .data_we  (data_we),
        .sel_reg  (sel_reg),
        .part     (part),
        .din      (din),
        .up_keyon (up_keyon),
        .ch_up    (ch_up),
        .op_up    (op_up),
        .up_ch    (up_ch),
        .up_op    (up_op),
        .slot_din (slot_din)
    );

    opn_busy i_busy (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .data_we (data_we),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// ==== hdl/opn_pcm_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_pcm_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_en,
    input  logic                   data_we,
    input  opn_reg_pkg::reg_addr_t sel_reg,
    input  logic                   part,
    input  opn_reg_pkg::reg_data_t din,
    output opn_reg_pkg::pcm_t      pcm,
    output logic                   pcm_en,
    output logic                   pcm_wr
);

    logic pcm_we;

    assign pcm_we = data_we && !part;   // DAC lives in part 0

    always_ff @(posedge clk) begin
        if (rst) begin
            pcm    <= '0;
            pcm_en <= 1'b0;
            pcm_wr <= 1'b0;
        end else if (pcm_we) begin
            case (sel_reg)
                // Offset binary to two's complement, half LSB added
                opn_reg_pkg::REG_PCM:     pcm    <= {~din[7], din[6:0], 1'b1};
                opn_reg_pkg::REG_DACTEST: pcm[0] <= din[3];
                opn_reg_pkg::REG_PCM_EN:  pcm_en <= din[7];
                default: ;
            endcase
            pcm_wr <= sel_reg == opn_reg_pkg::REG_PCM;
        end else if (clk_en && !data_we) begin
            pcm_wr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_reg_pkg.sv ====
`default_nettype none

package opn_reg_pkg;

    // Bus and register number
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Timer values
    typedef logic [9:0] timer_a_t;  // 0x24 holds the upper 8 bits
    typedef logic [7:0] timer_b_t;

    typedef logic [2:0] lfo_freq_t;

    // DAC sample, sign bit inverted, LSB forced high on 0x2A writes
    typedef logic [8:0] pcm_t;

    // Slot addressing for the external register file
    typedef logic [2:0] ch_t;       // {part, reg[1:0]}
    typedef logic [1:0] op_t;       // reg[3:2]

    // One-hot update strobes
    // Bit 0 fnum low, bit 1 fb/alg, bit 2 LFO sensitivity
    typedef logic [2:0] ch_up_t;
    // One bit per operator row, 0x30 up to 0x90
    typedef logic [6:0] op_up_t;

    // Global control registers, part 0 only
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;

    // DAC
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;

    // Prescaler, selecting the address is enough
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

endpackage

`default_nettype wire

// ==== hdl/opn_slot_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module opn_slot_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   data_we,
    input  opn_reg_pkg::reg_addr_t sel_reg,
    input  logic                   part,
    input  opn_reg_pkg::reg_data_t din,
    output logic                   up_keyon,
    output opn_reg_pkg::ch_up_t    ch_up,
    output opn_reg_pkg::op_up_t    op_up,
    output opn_reg_pkg::ch_t       up_ch,
    output opn_reg_pkg::op_t       up_op,
    output opn_reg_pkg::reg_data_t slot_din
);

    opn_reg_pkg::ch_up_t ch_up_nxt;
    opn_reg_pkg::op_up_t op_up_nxt;

    // Row decode, low bits 11 address no slot
    always_comb begin
        ch_up_nxt = '0;
        op_up_nxt = '0;
        if (sel_reg[1:0] != 2'b11) begin
            case (sel_reg[7:4])
                4'h3: op_up_nxt = 7'h01;    // DT1/MUL
                4'h4: op_up_nxt = 7'h02;    // TL
                4'h5: op_up_nxt = 7'h04;    // KS/AR
                4'h6: op_up_nxt = 7'h08;    // AM/DR
                4'h7: op_up_nxt = 7'h10;    // SR
                4'h8: op_up_nxt = 7'h20;    // SL/RR
                4'h9: op_up_nxt = 7'h40;    // SSG-EG
                4'hA: ch_up_nxt = (sel_reg[3:2] == 2'b00) ? 3'b001 : 3'b000;
                4'hB: begin
                    if (sel_reg[3:2] == 2'b00)
                        ch_up_nxt = 3'b010;     // FB/ALG
                    else if (sel_reg[3:2] == 2'b01)
                        ch_up_nxt = 3'b100;     // L/R, AMS, PMS
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_keyon <= 1'b0;
            ch_up    <= '0;
            op_up    <= '0;
        end else if (data_we) begin
            up_keyon <= !part && sel_reg == opn_reg_pkg::REG_KON;
            ch_up    <= ch_up_nxt;
            op_up    <= op_up_nxt;
        end
    end

    // Slot index and data byte for the register file
    always_ff @(posedge clk) begin
        if (data_we) begin
            slot_din <= din;
            up_ch    <= {part, sel_reg[1:0]};
            up_op    <= sel_reg[3:2];   // S1, S3, S2, S4 order
        end
    end

endmodule

`default_nettype wire

// ==== hdl/opn_timing_pkg.sv ====
`default_nettype none

package opn_timing_pkg;

    // Prescaler state, bit 1 set by 0x2D and bit 0 set by 0x2E
    typedef logic [1:0] div_setting_t;

    localparam div_setting_t DIV_RESET = 2'b10;    // divide by 6 out of reset

    // cen pulse counter and ratios
    typedef logic [2:0] div_cnt_t;

    localparam div_cnt_t DIV_BY_6 = 3'd6;
    localparam div_cnt_t DIV_BY_3 = 3'd3;
    localparam div_cnt_t DIV_BY_2 = 3'd2;

    // Busy lasts this many clk_en pulses after a data write
    localparam int BUSY_PULSES = 32;

    typedef logic [4:0] busy_cnt_t;

endpackage

`default_nettype wire

// ==== opn_mmr.f ====
hdl/opn_reg_pkg.sv
hdl/opn_timing_pkg.sv
hdl/opn_addr_port.sv
hdl/opn_clk_div.sv
hdl/opn_global_regs.sv
hdl/opn_pcm_regs.sv
hdl/opn_slot_decode.sv
hdl/opn_busy.sv
hdl/opn_mmr.sv
tb/tb_clk_gen.sv
tb/tb_opn_mmr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the opn_mmr testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_opn_mmr -f opn_mmr.f -o tb_opn_mmr

./obj_dir/tb_opn_mmr > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_opn_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_opn_mmr;

    localparam int WAIT_LIMIT = 2000;   // Cycles per wait loop
    localparam int BUSY_LEN   = 32;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  din;
    logic        write;
    logic [1:0]  addr;
    logic        clk_en;
    logic        busy;
    logic [2:0]  lfo_freq;
    logic [9:0]  value_a;
    logic [7:0]  value_b;
    logic        lfo_en, load_a, load_b, enable_irq_a, enable_irq_b;
    logic        clr_flag_a, clr_flag_b, fast_timers, eg_stop, pg_stop, csm, effect;
    logic [8:0]  pcm;
    logic        pcm_en, pcm_wr, up_keyon;
    logic [2:0]  ch_up;
    logic [6:0]  op_up;
    logic [2:0]  up_ch;
    logic [1:0]  up_op;
    logic [7:0]  slot_din;

    // Expected state
    logic [7:0]  m_reg;
    logic        m_part;
    logic [1:0]  exp_div;
    logic [11:0] exp_ctrl;
    logic [2:0]  exp_lfo;
    logic [9:0]  exp_value_a;
    logic [7:0]  exp_value_b;
    logic [8:0]  exp_pcm;
    logic        exp_pcm_en, exp_pcm_wr, exp_keyon, exp_busy, we_prev, slot_valid;
    logic [9:0]  exp_strobes;           // {ch_up, op_up}
    logic [2:0]  exp_up_ch;
    logic [1:0]  exp_up_op;
    logic [7:0]  exp_slot_din;
    int          busy_seen;
    int          cen_seen;
    logic        div_fresh;

    logic [11:0] dut_ctrl;
    logic        data_wr;
    logic        addr_wr;
    logic [15:0] data_lfsr = 16'd26;
    logic [15:0] cen_lfsr  = 16'd26;
    int          mismatches = 0;
    int          timeouts   = 0;

    assign data_wr  = write && addr[0];
    assign addr_wr  = write && !addr[0];
    assign dut_ctrl = {eg_stop, pg_stop, fast_timers, lfo_en, csm, effect,
                       clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a, load_b, load_a};

    tb_clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    opn_mmr i_opn_mmr (.*);

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            data_lfsr = galois_step(data_lfsr);
            value = {value[6:0], data_lfsr[0]};
        end
        return value;
    endfunction

    // cen pulses per clk_en for a prescaler state
    function automatic int ratio_of(input logic [1:0] setting);
        if (setting[0])
            return 3;
        else if (setting[1])
            return 6;
        return 2;
    endfunction

    // Register row to {ch_up, op_up}
    function automatic logic [9:0] slot_strobes(input logic [7:0] r);
        logic [9:0] s;
        s = '0;
        if (r[1:0] != 2'b11) begin
            if (r >= 8'h30 && r <= 8'h9F)
                s[r[7:4] - 4'd3] = 1'b1;
            else if (r[7:2] == 6'b101000)
                s[7] = 1'b1;            // A0-A2
            else if (r[7:2] == 6'b101100)
                s[8] = 1'b1;            // B0-B2
            else if (r[7:2] == 6'b101101)
                s[9] = 1'b1;            // B4-B6
        end
        return s;
    endfunction

    task automatic log_mismatch(input string what);
        mismatches++;
        $display("Mismatch at %0t ns: %s", $time, what);
    endtask

    task automatic addr_write(input logic part_sel, input logic [7:0] reg_num);
        @(negedge clk);
        write = 1'b1;
        addr  = {part_sel, 1'b0};
        din   = reg_num;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic data_write(input logic [7:0] value);
        @(negedge clk);
        write = 1'b1;
        addr  = 2'b01;
        din   = value;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic reg_write(input logic part_sel, input logic [7:0] reg_num,
                             input logic [7:0] value);
        addr_write(part_sel, reg_num);
        data_write(value);
    endtask

    task automatic wait_clk_en(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (clk_en)
                seen++;
            cycles++;
        end
        if (seen < count) begin
            timeouts++;
            $display("Timeout at %0t ns: only %0d of %0d clk_en pulses", $time, seen, count);
        end
    endtask

    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout at %0t ns: busy never went low", $time);
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (rst && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            timeouts++;
            $display("Timeout at %0t ns: reset was never released", $time);
        end
    endtask

    // Random cen, one LFSR bit per cycle
    initial begin
        cen = 1'b0;
        forever begin
            @(negedge clk);
            cen_lfsr = galois_step(cen_lfsr);
            cen = cen_lfsr[0];
        end
    end

    // Reference model of the register map
    always @(posedge clk) begin
        if (rst) begin
            m_reg       <= '0;
            m_part      <= 1'b0;
            exp_div     <= 2'b10;
            exp_ctrl    <= '0;
            exp_lfo     <= '0;
            exp_value_a <= '0;
            exp_value_b <= '0;
            exp_pcm     <= '0;
            exp_pcm_en  <= 1'b0;
            exp_pcm_wr  <= 1'b0;
            exp_keyon   <= 1'b0;
            exp_strobes <= '0;
            exp_busy    <= 1'b0;
            busy_seen   <= 0;
            we_prev     <= 1'b0;
            slot_valid  <= 1'b0;
        end else begin
            we_prev <= data_wr;
            if (addr_wr) begin
                m_reg  <= din;
                m_part <= addr[1];
                case (din)
                    8'h2D: exp_div[1] <= 1'b1;
                    8'h2E: exp_div[0] <= 1'b1;
                    8'h2F: exp_div    <= 2'b00;
                    default: ;
                endcase
            end
            if (data_wr) begin
                if (!m_part) begin
                    case (m_reg)
                        8'h21: exp_ctrl[11:9] <= {din[5], din[3], din[2]};
                        8'h22: begin
                            exp_ctrl[8] <= din[3];
                            exp_lfo     <= din[2:0];
                        end
                        8'h24: exp_value_a[9:2] <= din;
                        8'h25: exp_value_a[1:0] <= din[1:0];
                        8'h26: exp_value_b <= din;
                        8'h27: exp_ctrl[7:0] <= {din[7:6] == 2'b10, din[7:6] != 2'b00, din[5:0]};
                        8'h2A: exp_pcm <= {~din[7], din[6:0], 1'b1};
                        8'h2B: exp_pcm_en <= din[7];
                        8'h2C: exp_pcm[0] <= din[3];
                        default: ;
                    endcase
                    exp_pcm_wr <= m_reg == 8'h2A;
                end
                exp_strobes  <= slot_strobes(m_reg);
                exp_keyon    <= !m_part && m_reg == 8'h28;
                exp_up_ch    <= {m_part, m_reg[1:0]};
                exp_up_op    <= m_reg[3:2];
                exp_slot_din <= din;
                slot_valid   <= 1'b1;
            end else if (clk_en) begin
                exp_ctrl[5:4] <= 2'b00;     // Flag clears drop on idle clk_en
                exp_pcm_wr    <= 1'b0;
            end
            if (data_wr && !we_prev) begin
                exp_busy  <= 1'b1;
                busy_seen <= 0;
            end else if (exp_busy && clk_en) begin
                busy_seen <= busy_seen + 1;
                if (busy_seen + 1 == BUSY_LEN)
                    exp_busy <= 1'b0;
            end
        end
    end

    // cen pulses between clk_en, skipped for the first interval after a prescaler write
    always @(posedge clk) begin
        if (rst) begin
            cen_seen  <= 0;
            div_fresh <= 1'b0;
        end else begin
            if (clk_en) begin
                if (!div_fresh) begin
                    assert (cen_seen + 1 == ratio_of(exp_div))
                        else log_mismatch($sformatf("clk_en after %0d cen pulses, expected %0d",
                                                    cen_seen + 1, ratio_of(exp_div)));
                end
                cen_seen  <= 0;
                div_fresh <= 1'b0;
            end else if (cen) begin
                cen_seen <= cen_seen + 1;
            end
            if (addr_wr && din >= 8'h2D && din <= 8'h2F)
                div_fresh <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            assert (dut_ctrl == exp_ctrl)
                else log_mismatch($sformatf("control bits %h, expected %h", dut_ctrl, exp_ctrl));
            assert (lfo_freq == exp_lfo)
                else log_mismatch($sformatf("lfo_freq %h, expected %h", lfo_freq, exp_lfo));
            assert (value_a == exp_value_a && value_b == exp_value_b)
                else log_mismatch($sformatf("timers %h/%h, expected %h/%h",
                                            value_a, value_b, exp_value_a, exp_value_b));
            assert ({pcm_en, pcm_wr, pcm} == {exp_pcm_en, exp_pcm_wr, exp_pcm})
                else log_mismatch($sformatf("pcm_en/pcm_wr/pcm %b/%b/%h, expected %b/%b/%h",
                                            pcm_en, pcm_wr, pcm,
                                            exp_pcm_en, exp_pcm_wr, exp_pcm));
            assert ({up_keyon, ch_up, op_up} == {exp_keyon, exp_strobes})
                else log_mismatch($sformatf("keyon/ch_up/op_up %b/%b/%b, expected %b/%b",
                                            up_keyon, ch_up, op_up, exp_keyon, exp_strobes));
            assert (busy == exp_busy)
                else log_mismatch($sformatf("busy %b, expected %b", busy, exp_busy));
            if (slot_valid) begin
                assert ({up_ch, up_op, slot_din} == {exp_up_ch, exp_up_op, exp_slot_din})
                    else log_mismatch($sformatf("up_ch/up_op/slot_din %h/%h/%h, expected %h/%h/%h",
                                                up_ch, up_op, slot_din,
                                                exp_up_ch, exp_up_op, exp_slot_din));
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) clk_en |-> cen)
        else log_mismatch("clk_en high without cen");
    assert property (@(posedge clk) disable iff (rst) data_wr |=> busy)
        else log_mismatch("busy low after a data write");
    assert property (@(posedge clk) disable iff (rst) (addr_wr && !busy) |=> !busy)
        else log_mismatch("busy rose after an address write");

    initial begin
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        wait_reset_done();
        wait_clk_en(4);                 // Divide by 6 out of reset

        // Global registers, then the same numbers in part 1
        repeat (3) begin
            for (int r = 'h21; r <= 'h27; r++) begin
                if (r != 'h23)
                    reg_write(1'b0, r[7:0], rand_byte());
            end
        end
        for (int r = 'h21; r <= 'h27; r++)
            reg_write(1'b1, r[7:0], rand_byte());
        reg_write(1'b0, 8'h27, 8'hBF);  // CSM with every pulse bit
        wait_clk_en(2);
        reg_write(1'b0, 8'h27, 8'h7F);
        wait_clk_en(2);

        // DAC
        repeat (3) begin
            reg_write(1'b0, 8'h2C, rand_byte());
            reg_write(1'b0, 8'h2B, rand_byte());
            reg_write(1'b0, 8'h2A, rand_byte());
            wait_clk_en(2);
        end

        // Slot rows in both parts
        for (int p = 0; p < 2; p++) begin
            for (int r = 'h30; r < 'hC0; r++)
                reg_write(p[0], r[7:0], rand_byte());
            reg_write(p[0], 8'h28, rand_byte());
            reg_write(p[0], 8'h00, rand_byte());
            reg_write(p[0], 8'hFF, rand_byte());
        end

        // Prescaler by address writes alone
        addr_write(1'b0, 8'h2E);
        wait_clk_en(4);
        addr_write(1'b1, 8'h2F);
        wait_clk_en(4);
        addr_write(1'b0, 8'h2D);
        wait_clk_en(4);

        // Busy length and restart
        wait_busy_low();
        addr_write(1'b0, 8'h26);
        wait_clk_en(2);
        data_write(rand_byte());
        wait_busy_low();
        data_write(rand_byte());
        wait_clk_en(10);
        data_write(rand_byte());
        wait_busy_low();
        @(posedge clk);

        $display("Run complete: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
